//--- rtl/i2c_pkg.sv
package i2c_pkg;

	// device byte on the wire, seen whole or split into address and direction
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [6:0] addr;
			logic       rw;	// 1 = read
		} f;
	} addr_byte_u;

	localparam int BYTE_W = 8;
	localparam int QUARTERS = 4;	// i2c_clk cycles per scl bit
	localparam int Q_SAMPLE = 1;	// quarter where sda is sampled

	localparam logic RW_WRITE = 1'b0;
	localparam logic RW_READ = 1'b1;

	// start, dev, reg, val, stop
	localparam logic OP_WRITE = 1'b0;
	// start, dev, reg, stop, start, dev+r, data, stop
	localparam logic OP_READ = 1'b1;

	localparam int BIT_CYC = QUARTERS;
	localparam int BYTE_CYC = (BYTE_W + 1) * BIT_CYC;	// byte plus ack slot
	localparam int COND_CYC = QUARTERS;	// start or stop condition

	localparam int WR_FRAME_CYC = 2 * COND_CYC + 3 * BYTE_CYC;
	localparam int RD_FRAME_CYC = 4 * COND_CYC + 4 * BYTE_CYC;

endpackage

//--- rtl/i2c_seq_decode.sv
`timescale 1ns/1ps

module i2c_seq_decode #(
	parameter logic [6:0] SLAVE_ID = 7'h73,
	parameter logic [7:0] ID_REG = 8'h00,
	parameter logic [7:0] RD_ADDR = 8'h43,
	parameter logic [5:0] REG_NUM = 6'd51
) (
	input  logic                i2c_clk,
	input  logic                sys_rst_n,
	input  logic                cfg_ack,
	input  logic [23:0]         cfg_data,
	input  logic                cmd_ack,
	input  logic                cmd_nack,
	input  logic                id_ok,
	input  logic                id_fail,
	output logic                cfg_req,
	output logic                cmd_req,
	output logic                cmd_op,
	output i2c_pkg::addr_byte_u cmd_dev,
	output logic [7:0]          cmd_reg,
	output logic [7:0]          cmd_val,
	output logic                reading_id
);

	localparam logic [2:0] ID_WRITE = 3'd0;
	localparam logic [2:0] ID_READ = 3'd1;
	localparam logic [2:0] CFG_FETCH = 3'd2;
	localparam logic [2:0] CFG_WRITE = 3'd3;
	localparam logic [2:0] DATA_READ = 3'd4;

	logic [2:0] phase;
	logic [5:0] cfg_cnt;
	logic       wait_id;	// id read done, verdict pending
	logic       issue;
	logic       frame_done;
	logic       cfg_take;

	assign issue = !cmd_req && !cmd_ack && !wait_id && (phase != CFG_FETCH);
	assign frame_done = cmd_req && cmd_ack;
	assign cfg_take = (phase == CFG_FETCH) && cfg_req && cfg_ack;
	assign reading_id = (phase == ID_READ);

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			phase <= ID_WRITE;
			cmd_req <= 1'b0;
			cfg_req <= 1'b0;
			cfg_cnt <= '0;
			wait_id <= 1'b0;
		end else begin
			if (issue)
				cmd_req <= 1'b1;
			else if (frame_done)
				cmd_req <= 1'b0;

			case (phase)
				ID_WRITE: begin
					if (frame_done)
						phase <= ID_READ;
				end
				ID_READ: begin
					if (frame_done) begin
						if (cmd_nack)
							phase <= ID_WRITE;	// no answer, start over
						else
							wait_id <= 1'b1;
					end else if (id_ok) begin
						wait_id <= 1'b0;
						phase <= CFG_FETCH;
					end else if (id_fail) begin
						wait_id <= 1'b0;
						phase <= ID_WRITE;
					end
				end
				CFG_FETCH: begin
					if (!cfg_req && !cfg_ack) begin
						cfg_req <= 1'b1;
					end else if (cfg_take) begin
						cfg_req <= 1'b0;
						phase <= CFG_WRITE;
					end
				end
				CFG_WRITE: begin
					if (frame_done) begin
						cfg_cnt <= cfg_cnt + 1'b1;
						if (cfg_cnt == REG_NUM - 1'b1)
							phase <= DATA_READ;
						else
							phase <= CFG_FETCH;
					end
				end
				default: ;	// data read loops on its own
			endcase
		end
	end

	// command bytes, loaded as the request goes out
	always_ff @(posedge i2c_clk) begin
		if (cfg_take) begin
			cmd_op <= i2c_pkg::OP_WRITE;
			cmd_dev.raw <= cfg_data[23:16];
			cmd_reg <= cfg_data[15:8];
			cmd_val <= cfg_data[7:0];
		end else if (issue && phase != CFG_WRITE) begin
			cmd_op <= (phase == ID_WRITE) ? i2c_pkg::OP_WRITE : i2c_pkg::OP_READ;
			cmd_dev.f.addr <= SLAVE_ID;
			cmd_dev.f.rw <= i2c_pkg::RW_WRITE;
			cmd_reg <= (phase == DATA_READ) ? RD_ADDR : ID_REG;
			cmd_val <= 8'h00;
		end
	end

endmodule

//--- rtl/i2c_bit_exec.sv
`timescale 1ns/1ps

module i2c_bit_exec (
	input  logic                i2c_clk,
	input  logic                sys_rst_n,
	input  logic                cmd_req,
	input  logic                cmd_op,
	input  i2c_pkg::addr_byte_u cmd_dev,
	input  logic [7:0]          cmd_reg,
	input  logic [7:0]          cmd_val,
	input  logic                sda_in,
	output logic                cmd_ack,
	output logic                cmd_nack,
	output logic                scl,
	output logic                sda_oe,
	output logic                rx_bit,
	output logic                rx_strobe,
	output logic                rd_done
);

	localparam int Q_W = $clog2(i2c_pkg::QUARTERS);
	localparam int B_W = $clog2(i2c_pkg::BYTE_W);
	localparam logic [Q_W-1:0] Q_LAST = Q_W'(i2c_pkg::QUARTERS - 1);
	localparam logic [Q_W-1:0] Q_SAMPLE = Q_W'(i2c_pkg::Q_SAMPLE);
	localparam logic [B_W-1:0] B_LAST = B_W'(i2c_pkg::BYTE_W - 1);

	localparam logic [2:0] IDLE = 3'd0;
	localparam logic [2:0] START = 3'd1;
	localparam logic [2:0] BYTE = 3'd2;
	localparam logic [2:0] ACK = 3'd3;
	localparam logic [2:0] RDBYTE = 3'd4;
	localparam logic [2:0] NACK = 3'd5;
	localparam logic [2:0] STOP = 3'd6;
	localparam logic [2:0] RESTART = 3'd7;

	logic [2:0]          state;
	logic [Q_W-1:0]      q;
	logic [B_W-1:0]      bit_cnt;
	logic [1:0]          byte_idx;
	logic                second;	// past the repeated start of a read
	logic                nack_seen;
	logic                got_byte;
	i2c_pkg::addr_byte_u dev_tx;
	logic [7:0]          tx_byte;
	logic                last_byte;
	logic                q_end;
	logic                scl_mid;

	always_comb begin
		dev_tx = cmd_dev;
		if (second)
			dev_tx.f.rw = i2c_pkg::RW_READ;
	end

	always_comb begin
		case (byte_idx)
			2'd0: tx_byte = dev_tx.raw;
			2'd1: tx_byte = cmd_reg;
			default: tx_byte = cmd_val;
		endcase
	end

	assign last_byte = (cmd_op == i2c_pkg::OP_WRITE) ? (byte_idx == 2'd2) : (byte_idx == 2'd1);
	assign q_end = (q == Q_LAST);
	assign scl_mid = (q != '0) && (q != Q_LAST);
	assign cmd_nack = nack_seen;

	always_comb begin
		case (state)
			IDLE: begin
				scl = 1'b1;
				sda_oe = 1'b0;
			end
			START, RESTART: begin
				scl = (q != Q_LAST);
				sda_oe = (q != '0);	// sda falls with scl high
			end
			BYTE: begin
				scl = scl_mid;
				sda_oe = ~tx_byte[B_LAST - bit_cnt];	// msb first
			end
			STOP: begin
				scl = (q != '0);
				sda_oe = (q < Q_LAST - 1'b1);	// sda rises with scl high
			end
			default: begin
				scl = scl_mid;
				sda_oe = 1'b0;	// slave drives or nack
			end
		endcase
	end

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= IDLE;
			q <= '0;
			bit_cnt <= '0;
			byte_idx <= '0;
			second <= 1'b0;
			nack_seen <= 1'b0;
			got_byte <= 1'b0;
			cmd_ack <= 1'b0;
			rx_strobe <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			rx_strobe <= (state == RDBYTE) && (q == Q_SAMPLE);
			q <= (state == IDLE) ? '0 : q + 1'b1;

			case (state)
				IDLE: begin
					if (cmd_ack && !cmd_req) begin
						cmd_ack <= 1'b0;
					end else if (!cmd_ack && cmd_req) begin
						state <= START;
						byte_idx <= '0;
						second <= 1'b0;
						nack_seen <= 1'b0;
						got_byte <= 1'b0;
					end
				end
				START, RESTART: begin
					if (q_end) begin
						state <= BYTE;
						bit_cnt <= '0;
					end
				end
				BYTE: begin
					if (q_end) begin
						if (bit_cnt == B_LAST)
							state <= ACK;
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				ACK: begin
					if (q == Q_SAMPLE)
						nack_seen <= sda_in;
					if (q_end) begin
						if (nack_seen || (!second && last_byte)) begin
							state <= STOP;
						end else if (second) begin
							state <= RDBYTE;
						end else begin
							state <= BYTE;
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				RDBYTE: begin
					if (q_end) begin
						if (bit_cnt == B_LAST)
							state <= NACK;
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				NACK: begin
					if (q_end) begin
						state <= STOP;
						got_byte <= 1'b1;
					end
				end
				default: begin	// STOP
					if (q_end) begin
						if (cmd_op == i2c_pkg::OP_READ && !second && !nack_seen) begin
							state <= RESTART;
							second <= 1'b1;
							byte_idx <= '0;
						end else begin
							state <= IDLE;
							cmd_ack <= 1'b1;
							rd_done <= got_byte;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (state == RDBYTE && q == Q_SAMPLE)
			rx_bit <= sda_in;
	end

endmodule

//--- rtl/i2c_read_result.sv
`timescale 1ns/1ps

module i2c_read_result #(
	parameter logic [7:0] ID_VALUE = 8'h20
) (
	input  logic                        i2c_clk,
	input  logic                        sys_rst_n,
	input  logic                        rx_bit,
	input  logic                        rx_strobe,
	input  logic                        rd_done,
	input  logic                        reading_id,
	output logic                        id_ok,
	output logic                        id_fail,
	output logic [i2c_pkg::BYTE_W-1:0] po_data,
	output logic                        po_valid
);

	logic [i2c_pkg::BYTE_W-1:0] rx_sr;
	logic                       id_match;

	assign id_match = (rx_sr == ID_VALUE);

	always_ff @(posedge i2c_clk) begin
		if (rx_strobe)
			rx_sr <= {rx_sr[i2c_pkg::BYTE_W-2:0], rx_bit};	// msb arrives first
	end

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			id_ok <= 1'b0;
			id_fail <= 1'b0;
			po_valid <= 1'b0;
		end else begin
			id_ok <= rd_done && reading_id && id_match;
			id_fail <= rd_done && reading_id && !id_match;
			po_valid <= rd_done && !reading_id;
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (rd_done && !reading_id)
			po_data <= rx_sr;
	end

endmodule

//--- rtl/i2c_sensor_ctrl.sv
`timescale 1ns/1ps

module i2c_sensor_ctrl #(
	parameter logic [6:0] SLAVE_ID = 7'h73,
	parameter logic [7:0] ID_REG = 8'h00,
	parameter logic [7:0] ID_VALUE = 8'h20,
	parameter logic [7:0] RD_ADDR = 8'h43,
	parameter logic [5:0] REG_NUM = 6'd51
) (
	input  logic        i2c_clk,
	input  logic        sys_rst_n,
	input  logic        cfg_ack,
	input  logic [23:0] cfg_data,
	output logic        cfg_req,
	output logic        scl,
	output logic [7:0]  po_data,
	output logic        po_valid,
	inout  wire         sda
);

	logic                cmd_req;
	logic                cmd_op;
	i2c_pkg::addr_byte_u cmd_dev;
	logic [7:0]          cmd_reg;
	logic [7:0]          cmd_val;
	logic                cmd_ack;
	logic                cmd_nack;
	logic                reading_id;
	logic                id_ok;
	logic                id_fail;
	logic                sda_oe;
	logic                sda_in;
	logic                rx_bit;
	logic                rx_strobe;
	logic                rd_done;

	// open drain, pull-up sits outside
	assign sda = sda_oe ? 1'b0 : 1'bz;
	assign sda_in = sda;

	i2c_seq_decode #(
		.SLAVE_ID (SLAVE_ID),
		.ID_REG   (ID_REG),
		.RD_ADDR  (RD_ADDR),
		.REG_NUM  (REG_NUM)
	) u_decode (
		.i2c_clk    (i2c_clk),
		.sys_rst_n  (sys_rst_n),
		.cfg_ack    (cfg_ack),
		.cfg_data   (cfg_data),
		.cmd_ack    (cmd_ack),
		.cmd_nack   (cmd_nack),
		.id_ok      (id_ok),
		.id_fail    (id_fail),
		.cfg_req    (cfg_req),
		.cmd_req    (cmd_req),
		.cmd_op     (cmd_op),
		.cmd_dev    (cmd_dev),
		.cmd_reg    (cmd_reg),
		.cmd_val    (cmd_val),
		.reading_id (reading_id)
	);

	i2c_bit_exec u_exec (
		.i2c_clk   (i2c_clk),
		.sys_rst_n (sys_rst_n),
		.cmd_req   (cmd_req),
		.cmd_op    (cmd_op),
		.cmd_dev   (cmd_dev),
		.cmd_reg   (cmd_reg),
		.cmd_val   (cmd_val),
		.sda_in    (sda_in),
		.cmd_ack   (cmd_ack),
		.cmd_nack  (cmd_nack),
		.scl       (scl),
		.sda_oe    (sda_oe),
		.rx_bit    (rx_bit),
		.rx_strobe (rx_strobe),
		.rd_done   (rd_done)
	);

	i2c_read_result #(
		.ID_VALUE (ID_VALUE)
	) u_result (
		.i2c_clk    (i2c_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_bit     (rx_bit),
		.rx_strobe  (rx_strobe),
		.rd_done    (rd_done),
		.reading_id (reading_id),
		.id_ok      (id_ok),
		.id_fail    (id_fail),
		.po_data    (po_data),
		.po_valid   (po_valid)
	);

endmodule

//--- sim/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h73,
	parameter logic [7:0] RO_REG = 8'h00,
	parameter logic [7:0] FILL_XOR = 8'ha5
) (
	input  logic scl,
	inout  wire  sda
);

	logic [7:0] regs [256];
	logic [7:0] shift;
	logic [7:0] tx;
	logic [7:0] reg_ptr;
	logic [3:0] bit_cnt;
	logic [1:0] byte_no;
	logic       active;
	logic       sending;	// slave owns sda for data bits
	logic       ack_due;
	logic       rw;
	logic       drive_low;
	int         rd_count;

	assign sda = drive_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ FILL_XOR;
		shift = '0;
		tx = '0;
		reg_ptr = '0;
		bit_cnt = '0;
		byte_no = '0;
		active = 1'b0;
		sending = 1'b0;
		ack_due = 1'b0;
		rw = 1'b0;
		drive_low = 1'b0;
		rd_count = 0;
	end

	task automatic take_byte();
		if (byte_no == 2'd0) begin
			if (shift[7:1] == DEV_ADDR) begin
				ack_due = 1'b1;
				rw = shift[0];
			end else begin
				active = 1'b0;	// not our address
			end
		end else if (byte_no == 2'd1) begin
			reg_ptr = shift;
			ack_due = 1'b1;
		end else begin
			if (reg_ptr != RO_REG)
				regs[reg_ptr] = shift;	// id register ignores writes
			reg_ptr = reg_ptr + 1'b1;
			ack_due = 1'b1;
		end
	endtask

	always @(negedge sda) begin
		if (scl === 1'b1) begin	// start or repeated start
			active = 1'b1;
			sending = 1'b0;
			ack_due = 1'b0;
			bit_cnt = '0;
			byte_no = '0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin	// stop
			active = 1'b0;
			sending = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			if (bit_cnt < 4'd8) begin
				shift = {shift[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
				bit_cnt = bit_cnt + 1'b1;
				if (bit_cnt == 4'd8 && !sending)
					take_byte();
			end else begin
				bit_cnt = '0;
				if (sending) begin
					rd_count++;
					reg_ptr = reg_ptr + 1'b1;
					if (sda !== 1'b0)
						sending = 1'b0;	// master nack ends the read
					else
						tx = regs[reg_ptr];
				end else if (ack_due && rw) begin
					sending = 1'b1;
					tx = regs[reg_ptr];
				end
				ack_due = 1'b0;
				if (byte_no != 2'd2)
					byte_no = byte_no + 1'b1;
			end
		end
	end

	always @(negedge scl) begin
		if (!active)
			drive_low = 1'b0;
		else if (bit_cnt == 4'd8)
			drive_low = ack_due;
		else if (sending)
			drive_low = !tx[3'd7 - bit_cnt[2:0]];
		else
			drive_low = 1'b0;
	end

endmodule

//--- sim/i2c_bus_properties.sv
`timescale 1ns/1ps

module i2c_bus_properties (
	input logic i2c_clk,
	input logic sys_rst_n,
	input logic scl,
	input logic sda,
	input logic cfg_req,
	input logic cfg_ack
);

	// data may only move while scl is low
	scl_rise_sda_stable: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		$rose(scl) |-> $stable(sda))
		else $error("sda changed as scl rose");

	start_holds: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		(scl && $past(scl) && $fell(sda)) |=> (scl && !sda))
		else $error("start condition not held");

	stop_leaves_idle: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		(scl && $past(scl) && $rose(sda)) |=> (scl && sda))
		else $error("bus not idle after stop");

	req_falls_after_ack: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		$fell(cfg_req) |-> $past(cfg_ack))
		else $error("cfg_req dropped without cfg_ack");

	req_rise_ack_low: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		$rose(cfg_req) |-> !$past(cfg_ack))
		else $error("cfg_req raised while cfg_ack high");

endmodule

bind i2c_sensor_ctrl i2c_bus_properties u_bus_props (
	.i2c_clk   (i2c_clk),
	.sys_rst_n (sys_rst_n),
	.scl       (scl),
	.sda       (sda),
	.cfg_req   (cfg_req),
	.cfg_ack   (cfg_ack)
);

//--- sim/tb_i2c_sensor_ctrl.sv
`timescale 1ns/1ps

module tb_i2c_sensor_ctrl;

	localparam int CLK_PERIOD = 8;
	localparam logic [5:0] REG_NUM = 6'd4;
	localparam logic [7:0] RD_ADDR = 8'h43;
	localparam logic [7:0] FILL_XOR = 8'ha5;
	localparam int ID_TRIES = 4;
	localparam int RD_CHECKS = 3;
	localparam int N_FRAMES = 2 * ID_TRIES + REG_NUM + RD_CHECKS + 1;
	localparam int LIMIT_CYC = N_FRAMES * i2c_pkg::RD_FRAME_CYC * 2;

	logic        i2c_clk;
	logic        sys_rst_n;
	logic        cfg_ack;
	logic [23:0] cfg_data;
	logic        cfg_req;
	logic        scl;
	logic [7:0]  po_data;
	logic        po_valid;
	wire         sda;

	logic [7:0]  tbl_dev [4];
	logic [7:0]  tbl_reg [4];
	logic [7:0]  tbl_val [4];
	logic        tbl_acked [4];	// 0 = address nobody answers
	logic [31:0] lfsr;
	logic        cfg_req_seen;
	int          errors;
	int          checks;

	pullup (sda);

	i2c_sensor_ctrl #(.REG_NUM(REG_NUM), .RD_ADDR(RD_ADDR)) u_i2c_sensor_ctrl (
		.i2c_clk   (i2c_clk),
		.sys_rst_n (sys_rst_n),
		.cfg_ack   (cfg_ack),
		.cfg_data  (cfg_data),
		.cfg_req   (cfg_req),
		.scl       (scl),
		.po_data   (po_data),
		.po_valid  (po_valid),
		.sda       (sda)
	);

	i2c_slave_model #(.DEV_ADDR(7'h73), .RO_REG(8'h00), .FILL_XOR(FILL_XOR)) u_slave (
		.scl (scl),
		.sda (sda)
	);

	always #(CLK_PERIOD / 2) i2c_clk = ~i2c_clk;

	always @(negedge i2c_clk) begin
		if (cfg_req)
			cfg_req_seen <= 1'b1;
	end

	// taps 32 22 2 1
	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		logic       fb;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			b = {b[6:0], fb};
		end
		return b;
	endfunction

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic wait_po_valid();
		@(negedge i2c_clk);
		while (!po_valid)
			@(negedge i2c_clk);
	endtask

	initial begin
		#(LIMIT_CYC * CLK_PERIOD);
		$display("timeout after %0d cycles, the run did not finish", LIMIT_CYC);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [7:0] exp_rd;
		i2c_clk = 1'b0;
		sys_rst_n = 1'b0;
		cfg_ack = 1'b0;
		cfg_data = '0;
		cfg_req_seen = 1'b0;
		errors = 0;
		checks = 0;
		lfsr = 32'hc14dc41e;
		tbl_dev = '{8'he6, 8'he6, 8'haa, 8'he6};
		tbl_reg = '{8'h10, 8'h21, 8'h32, 8'h54};
		tbl_acked = '{1'b1, 1'b1, 1'b0, 1'b1};
		for (int i = 0; i < 4; i++)
			tbl_val[i] = random_byte();

		repeat (3) @(posedge i2c_clk);
		#1 sys_rst_n = 1'b1;
		@(negedge i2c_clk);
		check_flag(scl === 1'b1 && sda === 1'b1, "bus not idle after reset");
		check_flag(cfg_req === 1'b0, "cfg_req high after reset");

		// identity keeps failing until the register holds the right id
		while (u_slave.rd_count < 3)
			@(negedge i2c_clk);
		check_flag(!cfg_req_seen, "cfg_req rose before the identity matched");
		u_slave.regs[8'h00] = 8'h20;

		for (int i = 0; i < REG_NUM; i++) begin
			@(negedge i2c_clk);
			while (!cfg_req)
				@(negedge i2c_clk);
			@(posedge i2c_clk);
			#1;
			cfg_data = {tbl_dev[i], tbl_reg[i], tbl_val[i]};
			cfg_ack = 1'b1;
			@(negedge i2c_clk);
			while (cfg_req)
				@(negedge i2c_clk);
			@(posedge i2c_clk);
			#1 cfg_ack = 1'b0;
		end

		exp_rd = RD_ADDR ^ FILL_XOR;
		wait_po_valid();
		for (int i = 0; i < REG_NUM; i++) begin
			if (tbl_acked[i])
				check_value($sformatf("cfg write %0d", i), tbl_val[i], u_slave.regs[tbl_reg[i]]);
			else
				check_value($sformatf("nacked write %0d", i), tbl_reg[i] ^ FILL_XOR,
					u_slave.regs[tbl_reg[i]]);
		end
		check_value("data read 0", exp_rd, po_data);
		wait_po_valid();
		check_value("data read 1", exp_rd, po_data);
		exp_rd = 8'h3c;	// next read frame has not reached the data byte yet
		u_slave.regs[RD_ADDR] = exp_rd;
		wait_po_valid();
		check_value("data read after change", exp_rd, po_data);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
rtl/i2c_pkg.sv
rtl/i2c_seq_decode.sv
rtl/i2c_bit_exec.sv
rtl/i2c_read_result.sv
rtl/i2c_sensor_ctrl.sv
sim/i2c_slave_model.sv
sim/i2c_bus_properties.sv
sim/tb_i2c_sensor_ctrl.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_i2c_sensor_ctrl
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
